// File: Bender.yml
package:
  name: mapper_subsystem

sources:
  # design, in compile order
  - hw/mapper_pkg.sv
  - hw/ram_req_if.sv
  - hw/mapper_stage.sv
  - hw/mapper_ram.sv
  - hw/mapper_subsystem_top.sv

  # testbench and bound assertions
  - target: simulation
    files:
      - sim/mapper_sva.sv
      - sim/tb_mapper.sv

// File: filelist.f
hw/mapper_pkg.sv
hw/ram_req_if.sv
hw/mapper_stage.sv
hw/mapper_ram.sv
hw/mapper_subsystem_top.sv
sim/mapper_sva.sv
sim/tb_mapper.sv

// File: hw/mapper_pkg.sv
// shared widths and types for the memory mapper subsystem
// four 16 KB pages, each mapped through an 8-bit segment register
// the translated RAM address is segment & page offset, 22 bits in all
// segment ports are four consecutive I/O ports starting at seg_port_base
package mapper_pkg;

	// ------------------------------
	// bus and address widths
	// ------------------------------

	// cpu address bus
	localparam int bus_addr_w = 16;

	// one segment register
	localparam int seg_w = 8;

	// offset inside a 16 KB page, the bits below the page select
	localparam int page_off_w = bus_addr_w - 2;

	// translated RAM address, segment on top of the page offset
	localparam int ram_addr_w = seg_w + page_off_w;

	// cpu data bus
	localparam int data_w = 8;

	// I/O port of page 0 register, pages 1..3 follow
	localparam logic [7:0] seg_port_base = 8'hFC;

	// ------------------------------
	// types
	// ------------------------------

	// one segment register per page, index is address[15:14]
	typedef logic [seg_w-1:0] seg_regs_t [0:3];

	// RAM stage access sequence
	typedef enum logic [1:0] {
		ram_idle,
		ram_access,
		ram_done
	} ram_state_t;

	// request operation
	typedef enum logic {
		op_read,
		op_write
	} ram_op_t;

endpackage

// File: hw/mapper_ram.sv
// on-chip RAM stage with a fixed access latency
// ACCESS_CYCLES must be at least 1, RAM_ADDR_BITS at most 22
// only the low RAM_ADDR_BITS of the translated address are stored,
// higher segment bits alias onto the same bytes
// storage has no reset, contents are undefined until written
`timescale 1ns/1ps

module mapper_ram #(
	parameter int ACCESS_CYCLES = 3,
	parameter int RAM_ADDR_BITS = 16
) (
	input logic clk,
	input logic n_reset,
	ram_req_if.responder ram
);
	import mapper_pkg::*;

	// counter needs at least one bit, even for a single access cycle
	localparam int CNT_W = (ACCESS_CYCLES > 1) ? $clog2(ACCESS_CYCLES) : 1;
	localparam int DEPTH = 1 << RAM_ADDR_BITS;

	logic [data_w-1:0] mem [DEPTH];

	ram_state_t state_q;
	ram_state_t state_d;
	logic [CNT_W-1:0] cnt_q;
	logic last_cycle;

	// latched request
	ram_op_t op_q;
	logic [RAM_ADDR_BITS-1:0] addr_q;
	logic [data_w-1:0] wdata_q;

	logic [data_w-1:0] rdata_q;

	// ------------------------------
	// access state machine
	// ------------------------------

	// final cycle of the access phase
	assign last_cycle = (state_q == ram_access) && (cnt_q == CNT_W'(ACCESS_CYCLES - 1));

	always_comb begin
		state_d = state_q;
		case (state_q)
			ram_idle: begin
				if (ram.req_valid) begin
					state_d = ram_access;
				end
			end
			ram_access: begin
				if (last_cycle) begin
					state_d = ram_done;
				end
			end
			// single cycle, response goes out here
			ram_done: begin
				state_d = ram_idle;
			end
			default: begin
				state_d = ram_idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!n_reset) begin
			state_q <= ram_idle;
		end else begin
			state_q <= state_d;
		end
	end

	// counts cycles spent in ram_access, held at zero elsewhere
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			cnt_q <= '0;
		end else if (state_q == ram_access) begin
			cnt_q <= cnt_q + 1'b1;
		end else begin
			cnt_q <= '0;
		end
	end

	// ------------------------------
	// request latch and storage
	// ------------------------------

	// capture on acceptance, the mapper payload may move on afterwards
	always_ff @(posedge clk) begin
		if ((state_q == ram_idle) && ram.req_valid) begin
			op_q <= ram.req_op;
			addr_q <= ram.req_addr[RAM_ADDR_BITS-1:0];
			wdata_q <= ram.req_wdata;
		end
	end

	// array access happens on the edge into ram_done
	always_ff @(posedge clk) begin
		if (last_cycle) begin
			if (op_q == op_write) begin
				mem[addr_q] <= wdata_q;
			end else begin
				rdata_q <= mem[addr_q];
			end
		end
	end

	// ------------------------------
	// response
	// ------------------------------
	assign ram.busy = (state_q != ram_idle);
	assign ram.rdata = rdata_q;

	// pulse lasts exactly the ram_done cycle, reads only
	assign ram.rdata_en = (state_q == ram_done) && (op_q == op_read);

endmodule

// File: hw/mapper_stage.sv
// segment registers, I/O port decode and page translation
// segment registers load only on an I/O write, an I/O read has no effect
// a memory access is bus_memory with exactly one of bus_read / bus_write
// the bus must not start an access while busy is high, strobes are not queued
// segment registers cannot be read back over I/O
`timescale 1ns/1ps

module mapper_stage (
	input logic clk,
	input logic n_reset,
	input logic [mapper_pkg::bus_addr_w-1:0] bus_address,
	input logic [mapper_pkg::data_w-1:0] bus_write_data,
	input logic bus_read,
	input logic bus_write,
	input logic bus_io,
	input logic bus_memory,
	output logic busy,
	output logic [mapper_pkg::data_w-1:0] bus_read_data,
	output logic bus_read_ready,
	ram_req_if.requester ram
);
	import mapper_pkg::*;

	// segment register file, one per page
	seg_regs_t seg_q;

	// port decode
	logic [7:0] port_off;
	logic port_hit;
	logic seg_load;

	// translation
	logic [1:0] page;
	logic [ram_addr_w-1:0] xlate_addr;
	logic mem_strobe;

	// registered request
	logic req_valid_q;
	ram_op_t req_op_q;
	logic [ram_addr_w-1:0] req_addr_q;
	logic [data_w-1:0] req_wdata_q;

	// ------------------------------
	// I/O port decode
	// ------------------------------

	// offset from the page 0 port, wraps for ports below the base
	assign port_off = bus_address[7:0] - seg_port_base;
	assign port_hit = (port_off < 8'd4);

	// write only, a port read must not disturb the mapping
	assign seg_load = bus_io && bus_write && port_hit;

	// ------------------------------
	// segment registers
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			// all pages start on segment 0
			for (int i = 0; i < 4; i++) begin
				seg_q[i] <= '0;
			end
		end else if (seg_load) begin
			// low two bits of the offset select the page
			seg_q[port_off[1:0]] <= bus_write_data;
		end
	end

	// ------------------------------
	// page translation
	// ------------------------------

	// top two address bits pick the page
	assign page = bus_address[bus_addr_w-1 -: 2];

	// segment replaces the page bits, offset passes straight through
	assign xlate_addr = {seg_q[page], bus_address[page_off_w-1:0]};

	// read and write together is not an access
	assign mem_strobe = bus_memory && (bus_read != bus_write);

	// ------------------------------
	// request register
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			req_valid_q <= 1'b0;
		end else begin
			// one cycle pulse per sampled strobe
			req_valid_q <= mem_strobe;
		end
	end

	// payload, only meaningful with req_valid_q
	always_ff @(posedge clk) begin
		if (mem_strobe) begin
			req_op_q <= bus_write ? op_write : op_read;
			req_addr_q <= xlate_addr;
			req_wdata_q <= bus_write_data;
		end
	end

	assign ram.req_valid = req_valid_q;
	assign ram.req_op = req_op_q;
	assign ram.req_addr = req_addr_q;
	assign ram.req_wdata = req_wdata_q;

	// ------------------------------
	// bus side response
	// ------------------------------

	// pending request covers the gap before the RAM stage raises busy
	assign busy = req_valid_q || ram.busy;

	assign bus_read_ready = ram.rdata_en;

	// data bus reads zero outside the ready cycle
	assign bus_read_data = ram.rdata_en ? ram.rdata : '0;

endmodule

// File: hw/mapper_subsystem_top.sv
// memory mapper subsystem for an 8-bit expansion slot
// plain bus strobes and levels, no handshake beyond busy and read ready
// I/O writes to ports FCh..FFh load the page 0..3 segment registers
// read latency is ACCESS_CYCLES + 2 edges from the sampled strobe
// new accesses may only start while busy is low
`timescale 1ns/1ps

module mapper_subsystem_top #(
	parameter int ACCESS_CYCLES = 3,
	parameter int RAM_ADDR_BITS = 16
) (
	input logic clk,
	input logic n_reset,
	input logic [mapper_pkg::bus_addr_w-1:0] bus_address,
	input logic [mapper_pkg::data_w-1:0] bus_write_data,
	input logic bus_read,
	input logic bus_write,
	input logic bus_io,
	input logic bus_memory,
	output logic [mapper_pkg::data_w-1:0] bus_read_data,
	output logic bus_read_ready,
	output logic busy
);

	// ------------------------------
	// request link between stages
	// ------------------------------
	ram_req_if ram_req ();

	// ------------------------------
	// mapper stage
	// ------------------------------

	// port decode, translation and the request register
	mapper_stage u_mapper (
		.clk (clk),
		.n_reset (n_reset),
		.bus_address (bus_address),
		.bus_write_data (bus_write_data),
		.bus_read (bus_read),
		.bus_write (bus_write),
		.bus_io (bus_io),
		.bus_memory (bus_memory),
		.busy (busy),
		.bus_read_data (bus_read_data),
		.bus_read_ready (bus_read_ready),
		.ram (ram_req)
	);

	// ------------------------------
	// RAM stage
	// ------------------------------

	// storage with fixed latency
	mapper_ram #(
		.ACCESS_CYCLES (ACCESS_CYCLES),
		.RAM_ADDR_BITS (RAM_ADDR_BITS)
	) u_ram (
		.clk (clk),
		.n_reset (n_reset),
		.ram (ram_req)
	);

endmodule

// File: hw/ram_req_if.sv
// request and response link between the mapper and the RAM stage
// req_valid is a single cycle pulse, never sent while busy is high
// rdata is only meaningful in the cycle where rdata_en is high
`timescale 1ns/1ps

interface ram_req_if;
	import mapper_pkg::*;

	// request side, driven by the mapper
	logic req_valid;
	ram_op_t req_op;
	logic [ram_addr_w-1:0] req_addr;
	logic [data_w-1:0] req_wdata;

	// response side, driven by the RAM stage
	// busy is a level, high while an access is in flight
	logic busy;
	logic [data_w-1:0] rdata;
	logic rdata_en;

	// ------------------------------
	// mapper end
	// ------------------------------
	modport requester (
		output req_valid,
		output req_op,
		output req_addr,
		output req_wdata,
		input busy,
		input rdata,
		input rdata_en
	);

	// ------------------------------
	// RAM stage end
	// ------------------------------
	modport responder (
		input req_valid,
		input req_op,
		input req_addr,
		input req_wdata,
		output busy,
		output rdata,
		output rdata_en
	);

endinterface

// File: sim/mapper_sva.sv
// protocol assertions for the RAM stage, bound into mapper_ram
// sees the responder side of the request link and the access state
// fail_count lets the testbench include assertion failures in its verdict
`timescale 1ns/1ps

module mapper_sva (
	input logic clk,
	input logic n_reset,
	input logic req_valid,
	input mapper_pkg::ram_op_t req_op,
	input logic busy,
	input logic rdata_en,
	input mapper_pkg::ram_state_t state
);
	import mapper_pkg::*;

	int unsigned fail_count = 0;

	// operation of the request the RAM stage accepted last
	ram_op_t accepted_op;

	always_ff @(posedge clk) begin
		if (!n_reset) begin
			accepted_op <= op_read;
		end else if (req_valid && (state == ram_idle)) begin
			accepted_op <= req_op;
		end
	end

	// ------------------------------
	// request side
	// ------------------------------

	// the mapper holds off while the RAM stage is working
	a_no_req_when_busy: assert property (@(posedge clk) disable iff (!n_reset)
		req_valid |-> !busy)
		else begin
			$error("request arrived while the RAM stage was busy");
			fail_count++;
		end

	// ------------------------------
	// response side
	// ------------------------------

	// read pulse is a single cycle
	a_rdata_en_pulse: assert property (@(posedge clk) disable iff (!n_reset)
		rdata_en |=> !rdata_en)
		else begin
			$error("rdata_en stayed high for more than one cycle");
			fail_count++;
		end

	// a read answers in ram_done, a write never answers
	a_rdata_en_in_done: assert property (@(posedge clk) disable iff (!n_reset)
		rdata_en == ((state == ram_done) && (accepted_op == op_read)))
		else begin
			$error("rdata_en does not match the ram_done cycle of a read");
			fail_count++;
		end

	// quiet link straight after reset
	a_reset_quiet: assert property (@(posedge clk)
		!n_reset |=> (!busy && !rdata_en))
		else begin
			$error("busy or rdata_en high after reset");
			fail_count++;
		end

endmodule

bind mapper_ram mapper_sva u_sva (
	.clk (clk),
	.n_reset (n_reset),
	.req_valid (ram.req_valid),
	.req_op (ram.req_op),
	.busy (ram.busy),
	.rdata_en (ram.rdata_en),
	.state (state_q)
);

// File: sim/tb_mapper.sv
// testbench for the memory mapper subsystem
// random stimulus from a Galois LFSR, checked against a model of the
// segment registers and the stored bytes
// inputs change 1 ns after the rising edge, outputs are read there too
// since every DUT output comes from registers only
// bytes never written are undefined in the DUT, reads of them are not compared
`timescale 1ns/1ps

module tb_mapper;
	import mapper_pkg::*;

	localparam int ACCESS_CYCLES = 3;
	localparam int RAM_ADDR_BITS = 16;
	localparam int MEM_DEPTH = 1 << RAM_ADDR_BITS;
	// upper bound for any wait on busy
	localparam int WAIT_LIMIT = ACCESS_CYCLES + 16;

	logic clk;
	logic n_reset;
	logic [bus_addr_w-1:0] bus_address;
	logic [data_w-1:0] bus_write_data;
	logic bus_read;
	logic bus_write;
	logic bus_io;
	logic bus_memory;
	logic [data_w-1:0] bus_read_data;
	logic bus_read_ready;
	logic busy;

	logic [31:0] lfsr_state;

	// reference model
	seg_regs_t model_seg;
	logic [data_w-1:0] model_mem [MEM_DEPTH];
	bit model_written [MEM_DEPTH];

	mapper_subsystem_top #(
		.ACCESS_CYCLES (ACCESS_CYCLES),
		.RAM_ADDR_BITS (RAM_ADDR_BITS)
	) u_dut (
		.clk (clk),
		.n_reset (n_reset),
		.bus_address (bus_address),
		.bus_write_data (bus_write_data),
		.bus_read (bus_read),
		.bus_write (bus_write),
		.bus_io (bus_io),
		.bus_memory (bus_memory),
		.bus_read_data (bus_read_data),
		.bus_read_ready (bus_read_ready),
		.busy (busy)
	);

	always #2 clk = ~clk;

	// ------------------------------
	// random numbers
	// ------------------------------

	// x^32 + x^22 + x^2 + x + 1, right shifting
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h80200003;
		end
		return s >> 1;
	endfunction

	// one LFSR step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
		return v;
	endfunction

	// ------------------------------
	// model
	// ------------------------------

	// segment of the page replaces the top two address bits
	function automatic logic [ram_addr_w-1:0] model_xlate(input logic [bus_addr_w-1:0] a);
		return {model_seg[a[bus_addr_w-1 -: 2]], a[page_off_w-1:0]};
	endfunction

	// storage keeps only the low bits, higher segment bits alias
	function automatic int model_index(input logic [bus_addr_w-1:0] a);
		logic [ram_addr_w-1:0] full;
		full = model_xlate(a);
		return int'(full[RAM_ADDR_BITS-1:0]);
	endfunction

	// ------------------------------
	// checks
	// ------------------------------
	task automatic stop_with_error(input string why);
		$display("%s", why);
		$display("Regression failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic verify_rdata(input string name, input logic [data_w-1:0] actual,
			input logic [data_w-1:0] expected);
		if (actual !== expected) begin
			stop_with_error($sformatf("MISMATCH %s: got %h, expected %h", name, actual, expected));
		end
	endtask

	task automatic compare_addr(input string name, input logic [ram_addr_w-1:0] actual,
			input logic [ram_addr_w-1:0] expected);
		if (actual !== expected) begin
			stop_with_error($sformatf("MISMATCH %s: got %h, expected %h", name, actual, expected));
		end
	endtask

	// ------------------------------
	// bus cycles
	// ------------------------------
	task automatic step_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic release_bus();
		bus_read = 1'b0;
		bus_write = 1'b0;
		bus_io = 1'b0;
		bus_memory = 1'b0;
	endtask

	task automatic wait_not_busy();
		int n;
		n = 0;
		while (busy) begin
			if (n >= WAIT_LIMIT) begin
				stop_with_error("timeout: busy never fell before the next access");
			end
			step_cycle();
			n++;
		end
	endtask

	// one I/O cycle, port in the low address byte
	task automatic io_cycle(input logic [7:0] port, input logic [data_w-1:0] data,
			input logic wr);
		logic [7:0] off;
		off = port - seg_port_base;
		bus_address = {8'(rand_bits(8)), port};
		bus_write_data = data;
		bus_io = 1'b1;
		bus_write = wr;
		bus_read = !wr;
		// FCh..FFh name pages 0..3, writes only
		if (wr && (port >= seg_port_base)) begin
			model_seg[off[1:0]] = data;
		end
		step_cycle();
		release_bus();
	endtask

	// one memory access, returns when busy is low again
	task automatic run_access(input ram_op_t op, input logic [bus_addr_w-1:0] addr,
			input logic [data_w-1:0] wdata, output logic [data_w-1:0] rdata);
		int cycles;
		int ready_count;
		logic [ram_addr_w-1:0] exp_addr;
		exp_addr = model_xlate(addr);
		rdata = '0;
		ready_count = 0;
		wait_not_busy();
		bus_address = addr;
		bus_write_data = wdata;
		bus_memory = 1'b1;
		bus_read = (op == op_read);
		bus_write = (op == op_write);
		step_cycle();
		release_bus();
		cycles = 1;
		if (!busy || !u_dut.ram_req.req_valid) begin
			stop_with_error("no request and no busy one cycle after a memory strobe");
		end
		compare_addr("req_addr", u_dut.ram_req.req_addr, exp_addr);
		while (busy) begin
			if (bus_read_ready) begin
				if (op == op_write) begin
					stop_with_error("bus_read_ready pulsed during a write");
				end
				if (cycles != ACCESS_CYCLES + 2) begin
					stop_with_error($sformatf("read ready came after %0d cycles, expected %0d",
						cycles, ACCESS_CYCLES + 2));
				end
				ready_count++;
				rdata = bus_read_data;
			end else begin
				verify_rdata("bus_read_data", bus_read_data, '0);
			end
			if (cycles > WAIT_LIMIT) begin
				stop_with_error("timeout: busy stayed high during a memory access");
			end
			step_cycle();
			cycles++;
		end
		// busy must drop on the edge right after the ready cycle
		if (cycles != ACCESS_CYCLES + 3) begin
			stop_with_error($sformatf("busy fell after %0d cycles, expected %0d",
				cycles, ACCESS_CYCLES + 3));
		end
		if ((op == op_read) && (ready_count != 1)) begin
			stop_with_error($sformatf("read gave %0d ready pulses instead of one", ready_count));
		end
		verify_rdata("bus_read_data", bus_read_data, '0);
	endtask

	task automatic write_byte(input logic [bus_addr_w-1:0] addr, input logic [data_w-1:0] data);
		logic [data_w-1:0] unused;
		int idx;
		idx = model_index(addr);
		run_access(op_write, addr, data, unused);
		model_mem[idx] = data;
		model_written[idx] = 1'b1;
	endtask

	task automatic read_and_check(input logic [bus_addr_w-1:0] addr);
		logic [data_w-1:0] got;
		int idx;
		idx = model_index(addr);
		run_access(op_read, addr, '0, got);
		if (model_written[idx]) begin
			verify_rdata("bus_read_data", got, model_mem[idx]);
		end
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------
	initial begin
		logic [bus_addr_w-1:0] addr;
		logic [1:0] page;
		logic [7:0] port;
		clk = 1'b0;
		n_reset = 1'b0;
		bus_address = '0;
		bus_write_data = '0;
		release_bus();
		lfsr_state = 32'h9695d96c;
		for (int i = 0; i < 4; i++) begin
			model_seg[i] = '0;
		end
		repeat (5) @(posedge clk);
		#1;
		n_reset = 1'b1;
		step_cycle();

		// every page on segment 0, offsets alias across pages
		for (int i = 0; i < 16; i++) begin
			addr = bus_addr_w'(rand_bits(16));
			write_byte(addr, data_w'(rand_bits(8)));
			page = 2'(rand_bits(2));
			read_and_check({page, addr[page_off_w-1:0]});
		end

		// segment ports change the mapping
		for (int i = 0; i < 12; i++) begin
			io_cycle({6'h3F, 2'(rand_bits(2))}, data_w'(rand_bits(8)), 1'b1);
			addr = bus_addr_w'(rand_bits(16));
			write_byte(addr, data_w'(rand_bits(8)));
			read_and_check(addr);
		end

		// other ports and an I/O read leave the mapping alone
		addr = bus_addr_w'(rand_bits(16));
		write_byte(addr, data_w'(rand_bits(8)));
		for (int i = 0; i < 8; i++) begin
			port = 8'(rand_bits(8));
			if (port >= seg_port_base) begin
				port = port - 8'h10;
			end
			io_cycle(port, data_w'(rand_bits(8)), 1'b1);
		end
		io_cycle(seg_port_base, data_w'(rand_bits(8)), 1'b0);
		// all four pages, so every segment register is looked at
		for (int p = 0; p < 4; p++) begin
			read_and_check({2'(p), addr[page_off_w-1:0]});
		end

		// segments 05h and 45h share their stored bits
		io_cycle(8'hFC, 8'h05, 1'b1);
		io_cycle(8'hFD, 8'h45, 1'b1);
		write_byte(16'h0123, data_w'(rand_bits(8)));
		read_and_check(16'h4123);

		// random mix on a small offset range so reads hit written bytes
		for (int i = 0; i < 300; i++) begin
			addr = {2'(rand_bits(2)), 9'h000, 5'(rand_bits(5))};
			if (rand_bits(4) == 0) begin
				io_cycle({6'h3F, 2'(rand_bits(2))}, data_w'(rand_bits(8)), 1'b1);
			end else if (rand_bits(1) != 0) begin
				write_byte(addr, data_w'(rand_bits(8)));
			end else begin
				read_and_check(addr);
			end
		end

		// let the last assertions settle
		step_cycle();
		step_cycle();
		if (u_dut.u_ram.u_sva.fail_count == 0) begin
			$display("Regression passed");
			$finish;
		end else begin
			$display("Regression failed");
			$fatal(1, "%0d assertion failures", u_dut.u_ram.u_sva.fail_count);
		end
	end

endmodule
